// ==== src/vec_pkg.sv ====
package vec_pkg;

    // one fixed-point lane
    localparam int word_bits = 32;

    // lanes per vector
    localparam int vec_lanes = 3;

    // flattened vector, lane 0 in the low bits
    localparam int vec_bits = word_bits * vec_lanes;

    // input job word holds a, b and y
    localparam int job_bits = 3 * vec_bits;

    // middle word holds d and y
    localparam int mid_bits = 2 * vec_bits;

endpackage

// ==== src/sync_fifo.sv ====
`timescale 1ns/1ps

// single clock FIFO, first word falls through to dout
// DEPTH is expected to be a power of two
module sync_fifo #(
    parameter int WIDTH = 32,
    parameter int DEPTH = 8
) (
    input  logic             clock,
    input  logic             reset,

    input  logic             wr_en,
    input  logic [WIDTH-1:0] din,
    output logic             full,

    input  logic             rd_en,
    output logic [WIDTH-1:0] dout,
    output logic             empty
);

    localparam int addr_bits = $clog2(DEPTH);

    logic [WIDTH-1:0]   mem [DEPTH];

    // extra top bit tells a full ring from an empty one
    logic [addr_bits:0] wr_ptr;
    logic [addr_bits:0] rd_ptr;

    logic               push;
    logic               pop;

    // requests that hit a blocking flag are dropped
    assign push = wr_en && !full;
    assign pop  = rd_en && !empty;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[addr_bits] != rd_ptr[addr_bits]) &&
                   (wr_ptr[addr_bits-1:0] == rd_ptr[addr_bits-1:0]);

    // oldest entry shown without waiting for a read
    assign dout = mem[rd_ptr[addr_bits-1:0]];

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
        end else if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            rd_ptr <= '0;
        end else if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

    // write side of the ring
    always_ff @(posedge clock) begin
        if (push) begin
            mem[wr_ptr[addr_bits-1:0]] <= din;
        end
    end

endmodule

// ==== src/vec_sub_stage.sv ====
`timescale 1ns/1ps

// first pipeline stage, d = a - b per lane with y carried along
module vec_sub_stage (
    input  logic                         clock,
    input  logic                         reset,

    input  logic [vec_pkg::job_bits-1:0] job,
    input  logic                         job_empty,
    output logic                         job_rd_en,

    output logic [vec_pkg::mid_bits-1:0] mid,
    input  logic                         mid_full,
    output logic                         mid_wr_en
);

    import vec_pkg::*;

    localparam logic st_take = 1'b0;
    localparam logic st_give = 1'b1;

    logic                 state;
    logic                 next_state;

    logic [word_bits-1:0] a_lane [vec_lanes];
    logic [word_bits-1:0] b_lane [vec_lanes];
    logic [vec_bits-1:0]  d_vec;
    logic [vec_bits-1:0]  y_vec;

    // job layout from low to high is a, b, y
    always_comb begin
        for (int i = 0; i < vec_lanes; i++) begin
            a_lane[i] = job[i*word_bits +: word_bits];
            b_lane[i] = job[vec_bits + i*word_bits +: word_bits];
            // plain 32 bit wrap on overflow
            d_vec[i*word_bits +: word_bits] = a_lane[i] - b_lane[i];
        end
    end

    assign y_vec = job[2*vec_bits +: vec_bits];

    // take pops one job, give pushes it downstream
    always_comb begin
        next_state = state;
        job_rd_en  = 1'b0;
        mid_wr_en  = 1'b0;

        case (state)
            st_take: begin
                if (!job_empty) begin
                    job_rd_en  = 1'b1;
                    next_state = st_give;
                end
            end
            st_give: begin
                if (!mid_full) begin
                    mid_wr_en  = 1'b1;
                    next_state = st_take;
                end
            end
            default: next_state = st_take;
        endcase
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= st_take;
        end else begin
            state <= next_state;
        end
    end

    // result held here until the middle FIFO has room
    always_ff @(posedge clock) begin
        if (job_rd_en) begin
            mid <= {y_vec, d_vec};
        end
    end

endmodule

// ==== src/dot_stage.sv ====
`timescale 1ns/1ps

// second pipeline stage, Q-format dot product of d and y
module dot_stage #(
    parameter int Q_BITS = 16
) (
    input  logic                                clock,
    input  logic                                reset,

    input  logic        [vec_pkg::mid_bits-1:0] mid,
    input  logic                                mid_empty,
    output logic                                mid_rd_en,

    output logic signed [vec_pkg::word_bits-1:0] res,
    input  logic                                res_full,
    output logic                                res_wr_en
);

    import vec_pkg::*;

    localparam logic st_take = 1'b0;
    localparam logic st_give = 1'b1;

    logic                        state;
    logic                        next_state;

    logic signed [word_bits-1:0] d_lane  [vec_lanes];
    logic signed [word_bits-1:0] y_lane  [vec_lanes];
    logic signed [63:0]          prod    [vec_lanes];
    logic signed [63:0]          shifted [vec_lanes];
    logic signed [63:0]          sum;
    logic signed [word_bits-1:0] res_c;

    // d sits in the low vector, y in the high one
    always_comb begin
        sum = '0;
        for (int i = 0; i < vec_lanes; i++) begin
            d_lane[i]  = mid[i*word_bits +: word_bits];
            y_lane[i]  = mid[vec_bits + i*word_bits +: word_bits];
            // both operands signed so they extend to 64 bits
            prod[i]    = d_lane[i] * y_lane[i];
            // arithmetic shift floors toward minus infinity
            shifted[i] = prod[i] >>> Q_BITS;
            sum        = sum + shifted[i];
        end
        res_c = sum[word_bits-1:0];
    end

    always_comb begin
        next_state = state;
        mid_rd_en  = 1'b0;
        res_wr_en  = 1'b0;

        case (state)
            st_take: begin
                if (!mid_empty) begin
                    mid_rd_en  = 1'b1;
                    next_state = st_give;
                end
            end
            st_give: begin
                if (!res_full) begin
                    res_wr_en  = 1'b1;
                    next_state = st_take;
                end
            end
            default: next_state = st_take;
        endcase
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= st_take;
            res   <= '0;
        end else begin
            state <= next_state;
            // capture only on the pop
            if (mid_rd_en) begin
                res <= res_c;
            end
        end
    end

endmodule

// ==== src/vec_dot_pipeline.sv ====
`timescale 1ns/1ps

// in_fifo -> subtract -> mid_fifo -> dot -> out_fifo
module vec_dot_pipeline #(
    parameter int Q_BITS     = 16,
    parameter int FIFO_DEPTH = 8
) (
    input  logic                                 clock,
    input  logic                                 reset,

    input  logic signed [vec_pkg::word_bits-1:0] a0,
    input  logic signed [vec_pkg::word_bits-1:0] a1,
    input  logic signed [vec_pkg::word_bits-1:0] a2,
    input  logic signed [vec_pkg::word_bits-1:0] b0,
    input  logic signed [vec_pkg::word_bits-1:0] b1,
    input  logic signed [vec_pkg::word_bits-1:0] b2,
    input  logic signed [vec_pkg::word_bits-1:0] y0,
    input  logic signed [vec_pkg::word_bits-1:0] y1,
    input  logic signed [vec_pkg::word_bits-1:0] y2,
    input  logic                                 in_wr_en,
    output logic                                 in_full,

    output logic signed [vec_pkg::word_bits-1:0] result,
    output logic                                 out_empty,
    input  logic                                 out_rd_en
);

    import vec_pkg::*;

    // input side
    logic [job_bits-1:0]         job_din;
    logic [job_bits-1:0]         job_dout;
    logic                        job_empty;
    logic                        job_rd_en;

    // between the two stages
    logic [mid_bits-1:0]         mid_din;
    logic                        mid_full;
    logic                        mid_wr_en;
    logic [mid_bits-1:0]         mid_dout;
    logic                        mid_empty;
    logic                        mid_rd_en;

    // dot stage into the output FIFO
    logic signed [word_bits-1:0] res_din;
    logic                        res_full;
    logic                        res_wr_en;

    // lane 0 lowest, then a, b, y from low to high
    assign job_din = {y2, y1, y0, b2, b1, b0, a2, a1, a0};

    sync_fifo #(
        .WIDTH (job_bits),
        .DEPTH (FIFO_DEPTH)
    ) in_fifo (
        .clock (clock),
        .reset (reset),
        .wr_en (in_wr_en),
        .din   (job_din),
        .full  (in_full),
        .rd_en (job_rd_en),
        .dout  (job_dout),
        .empty (job_empty)
    );

    vec_sub_stage u_vec_sub_stage (
        .clock     (clock),
        .reset     (reset),
        .job       (job_dout),
        .job_empty (job_empty),
        .job_rd_en (job_rd_en),
        .mid       (mid_din),
        .mid_full  (mid_full),
        .mid_wr_en (mid_wr_en)
    );

    sync_fifo #(
        .WIDTH (mid_bits),
        .DEPTH (FIFO_DEPTH)
    ) mid_fifo (
        .clock (clock),
        .reset (reset),
        .wr_en (mid_wr_en),
        .din   (mid_din),
        .full  (mid_full),
        .rd_en (mid_rd_en),
        .dout  (mid_dout),
        .empty (mid_empty)
    );

    dot_stage #(
        .Q_BITS (Q_BITS)
    ) u_dot_stage (
        .clock     (clock),
        .reset     (reset),
        .mid       (mid_dout),
        .mid_empty (mid_empty),
        .mid_rd_en (mid_rd_en),
        .res       (res_din),
        .res_full  (res_full),
        .res_wr_en (res_wr_en)
    );

    sync_fifo #(
        .WIDTH (word_bits),
        .DEPTH (FIFO_DEPTH)
    ) out_fifo (
        .clock (clock),
        .reset (reset),
        .wr_en (res_wr_en),
        .din   (res_din),
        .full  (res_full),
        .rd_en (out_rd_en),
        .dout  (result),
        .empty (out_empty)
    );

endmodule

// ==== tb/vec_dot_pipeline_tb.sv ====
`timescale 1ns/1ps

module vec_dot_pipeline_tb;

    import vec_pkg::*;

    localparam int q_bits        = 16;
    localparam int fifo_depth    = 8;
    localparam int rand_seed     = 32'h2054e3ab;
    localparam int stream_jobs   = 24;
    localparam int max_cycles    = 4000;
    localparam int result_wait   = 64;
    localparam logic [31:0] one  = 32'h0001_0000;
    localparam logic [31:0] half = 32'h0000_8000;

    logic clock;
    logic reset;
    logic signed [word_bits-1:0] a0, a1, a2, b0, b1, b2, y0, y1, y2;
    logic in_wr_en;
    logic in_full;
    logic signed [word_bits-1:0] result;
    logic out_empty;
    logic out_rd_en;

    logic [word_bits-1:0] exp_q [$];
    int error_count;
    int cycle_count;

    vec_dot_pipeline #(
        .Q_BITS     (q_bits),
        .FIFO_DEPTH (fifo_depth)
    ) uut (
        .clock     (clock),
        .reset     (reset),
        .a0        (a0),
        .a1        (a1),
        .a2        (a2),
        .b0        (b0),
        .b1        (b1),
        .b2        (b2),
        .y0        (y0),
        .y1        (y1),
        .y2        (y2),
        .in_wr_en  (in_wr_en),
        .in_full   (in_full),
        .result    (result),
        .out_empty (out_empty),
        .out_rd_en (out_rd_en)
    );

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    // hard stop if a handshake never completes
    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= max_cycles) begin
            $display("timeout: run stopped after %0d cycles", cycle_count);
            $display("errors: %0d", error_count);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    function automatic logic [vec_bits-1:0] vec3(input logic [31:0] x0, x1, x2);
        return {x2, x1, x0};
    endfunction

    // wrapped difference, 64 bit product, floor shift, 64 bit sum
    function automatic logic [word_bits-1:0] model_dot(input logic [vec_bits-1:0] av, bv, yv);
        logic signed [31:0] d;
        logic signed [31:0] y;
        longint             p;
        longint             sum;
        sum = 0;
        for (int i = 0; i < vec_lanes; i++) begin
            d   = av[i*32 +: 32] - bv[i*32 +: 32];
            y   = yv[i*32 +: 32];
            p   = longint'(d) * longint'(y);
            sum = sum + (p >>> q_bits);
        end
        return sum[31:0];
    endfunction

    task automatic random_job(output logic [vec_bits-1:0] av, bv, yv);
        av = vec3($urandom, $urandom, $urandom);
        bv = vec3($urandom, $urandom, $urandom);
        yv = vec3($urandom, $urandom, $urandom);
    endtask

    // sets the input lanes and queues the expected word
    task automatic drive_job(input logic [vec_bits-1:0] av, bv, yv);
        {a2, a1, a0} = av;
        {b2, b1, b0} = bv;
        {y2, y1, y0} = yv;
        exp_q.push_back(model_dot(av, bv, yv));
    endtask

    task automatic check_result(input logic [word_bits-1:0] got);
        logic [word_bits-1:0] expected;
        assert (exp_q.size() > 0) else begin
            error_count++;
            $display("result %h came out with no job outstanding", got);
        end
        if (exp_q.size() > 0) begin
            expected = exp_q.pop_front();
            assert (got == expected) else begin
                error_count++;
                $display("Fail at %0t: expected %h, got %h", $time, expected, got);
            end
        end
    endtask

    task automatic push_job(input logic [vec_bits-1:0] av, bv, yv);
        @(negedge clock);
        while (in_full) @(negedge clock);
        drive_job(av, bv, yv);
        in_wr_en = 1'b1;
        @(negedge clock);
        in_wr_en = 1'b0;
    endtask

    // gives up after a while so a lost result shows as a leftover
    task automatic pop_one();
        int waited;
        waited = 0;
        @(negedge clock);
        while (out_empty && waited < result_wait) begin
            @(negedge clock);
            waited++;
        end
        if (!out_empty) begin
            check_result(result);
            out_rd_en = 1'b1;
            @(negedge clock);
            out_rd_en = 1'b0;
        end
    endtask

    // nothing extra may appear once all expected words are out
    task automatic check_drained();
        repeat (8) @(negedge clock);
        assert (out_empty) else begin
            error_count++;
            $display("output FIFO still holds a result after draining");
        end
        assert (exp_q.size() == 0) else begin
            error_count++;
            $display("%0d expected results were never produced", exp_q.size());
        end
    endtask

    task automatic check_model(input logic [vec_bits-1:0] av, bv, yv,
                               input logic [word_bits-1:0] hand);
        assert (model_dot(av, bv, yv) == hand) else begin
            error_count++;
            $display("reference model disagrees with hand value %h", hand);
        end
    endtask

    task automatic test_reset_flags();
        assert (out_empty && !in_full) else begin
            error_count++;
            $display("flags wrong after reset: out_empty %b, in_full %b", out_empty, in_full);
        end
    endtask

    task automatic test_single_job();
        logic [vec_bits-1:0] av, bv, yv;
        av = vec3(3 * one, one, 0);
        bv = vec3(one, 0, 0);
        yv = vec3(half, 2 * one, 4 * one);
        check_model(av, bv, yv, 32'h0003_0000);
        push_job(av, bv, yv);
        pop_one();
        check_drained();
    endtask

    task automatic test_signed_floor();
        logic [vec_bits-1:0] av, bv, yv;
        // -3.0 times 1.5
        av = vec3(-2 * one, 0, 0);
        bv = vec3(one, 0, 0);
        yv = vec3(one + half, 0, 0);
        check_model(av, bv, yv, 32'hfffb_8000);
        push_job(av, bv, yv);
        // -1 lsb floors to -1
        check_model(vec3(0, 0, 0), vec3(1, 0, 0), vec3(1, 0, 0), 32'hffff_ffff);
        push_job(vec3(0, 0, 0), vec3(1, 0, 0), vec3(1, 0, 0));
        // +1 lsb floors to zero
        check_model(vec3(0, 1, 0), vec3(0, 0, 0), vec3(0, 1, 0), 32'h0000_0000);
        push_job(vec3(0, 1, 0), vec3(0, 0, 0), vec3(0, 1, 0));
        repeat (3) pop_one();
        check_drained();
    endtask

    task automatic test_stream(input int n);
        logic [vec_bits-1:0] av, bv, yv;
        int sent;
        int idle;
        sent = 0;
        idle = 0;
        while ((sent < n || exp_q.size() > 0) && idle < result_wait) begin
            @(negedge clock);
            in_wr_en  = 1'b0;
            out_rd_en = 1'b0;
            if (!out_empty) begin
                check_result(result);
                out_rd_en = 1'b1;
                idle = 0;
            end else begin
                idle++;
            end
            if (sent < n && !in_full) begin
                random_job(av, bv, yv);
                drive_job(av, bv, yv);
                in_wr_en = 1'b1;
                sent++;
            end
        end
        @(negedge clock);
        in_wr_en  = 1'b0;
        out_rd_en = 1'b0;
        check_drained();
    endtask

    task automatic test_backpressure();
        logic [vec_bits-1:0] av, bv, yv;
        int stored;
        int stalled;
        stored  = 0;
        stalled = 0;
        // fill until in_full stays up
        while (stalled < 12) begin
            @(negedge clock);
            in_wr_en = 1'b0;
            if (in_full) begin
                stalled++;
            end else begin
                stalled = 0;
                random_job(av, bv, yv);
                drive_job(av, bv, yv);
                in_wr_en = 1'b1;
                stored++;
            end
        end
        assert (stored >= 3 * fifo_depth) else begin
            error_count++;
            $display("pipeline filled after only %0d jobs", stored);
        end
        repeat (stored) pop_one();
        check_drained();
    endtask

    initial begin
        error_count = 0;
        cycle_count = 0;
        void'($urandom(rand_seed));
        reset       = 1'b1;
        in_wr_en    = 1'b0;
        out_rd_en   = 1'b0;
        {a2, a1, a0, b2, b1, b0, y2, y1, y0} = '0;
        repeat (16) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        @(negedge clock);

        test_reset_flags();
        test_single_job();
        test_signed_floor();
        test_stream(stream_jobs);
        test_backpressure();

        $display("errors: %0d", error_count);
        if (error_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// ==== files.f ====
src/vec_pkg.sv
src/sync_fifo.sv
src/vec_sub_stage.sv
src/dot_stage.sv
src/vec_dot_pipeline.sv
tb/vec_dot_pipeline_tb.sv
